// File: rtl/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // One bus word and the width of every SRAM row
    typedef logic [31:0] word_t;

    // Byte address whose word index starts at bit 2
    typedef logic [31:0] addr_t;

    // Bit n enables byte n of the word
    typedef logic [3:0] byte_en_t;

    // Default of 1024 words
    localparam int MEM_DEPTH_LOG2 = 10;

endpackage : mem_pkg

`default_nettype wire

// File: rtl/slot_pkg.sv
`default_nettype none

package slot_pkg;

    // Length of one arbitration round in clk2x cycles
    localparam int NUM_SLOTS = 4;

    // One-hot slot ring where each value names the edge it acts on
    typedef enum logic [NUM_SLOTS-1:0] {
        SLOT_ISSUE1   = 4'b0001,
        SLOT_ISSUE2   = 4'b0010,
        SLOT_CAPTURE2 = 4'b0100,
        SLOT_IDLE     = 4'b1000
    } slot_t;

endpackage : slot_pkg

`default_nettype wire

// File: rtl/sram_model.sv
`timescale 1ns/100ps
`default_nettype none

module sram_model #(
    parameter int depth_log2 = mem_pkg::MEM_DEPTH_LOG2
) (
    input  wire logic              clk2x,
    input  wire mem_pkg::addr_t    ram_address,
    input  wire mem_pkg::word_t    ram_data_o,
    input  wire logic              ram_wr_n,
    input  wire logic              ram_rd_n,
    input  wire mem_pkg::byte_en_t dataenable,
    output mem_pkg::word_t         ram_data_i
);

    import mem_pkg::*;

    localparam int NUM_BYTES = $bits(byte_en_t);

    word_t                   mem [0:(1 << depth_log2) - 1];
    logic [depth_log2-1:0]   word_idx;

    // Byte offset bits are ignored
    assign word_idx = ram_address[depth_log2+1:2];

    initial begin
        for (int i = 0; i < (1 << depth_log2); i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk2x) begin
        if (!ram_wr_n) begin
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (dataenable[b]) begin
                    mem[word_idx][8*b +: 8] <= ram_data_o[8*b +: 8];
                end
            end
        end
    end

    // Read is combinational on the registered address from the arbiter
    assign ram_data_i = ram_rd_n ? '0 : mem[word_idx];

endmodule : sram_model

`default_nettype wire

// File: rtl/port_adapter.sv
`timescale 1ns/100ps
`default_nettype none

module port_adapter (
    input  wire logic              clk2x,
    input  wire logic              rst_n,
    input  wire logic              req_valid,
    input  wire logic              req_write,
    input  wire mem_pkg::addr_t    req_addr,
    input  wire mem_pkg::word_t    req_wdata,
    input  wire mem_pkg::byte_en_t req_be,
    output logic                   req_ready,
    output logic                   rsp_valid,
    output mem_pkg::word_t         rsp_rdata,
    output logic                   rd,
    output logic                   wr,
    output mem_pkg::addr_t         address,
    output mem_pkg::word_t         wrdata,
    output mem_pkg::byte_en_t      dataenable,
    input  wire logic              ack,
    input  wire mem_pkg::word_t    rddata
);

    logic pending;
    logic is_write;
    logic accept;

    // Only one request in flight, so ready simply follows the empty holder
    assign req_ready = !pending;
    assign accept    = req_valid && req_ready;

    assign rd = pending && !is_write;
    assign wr = pending && is_write;

    always_ff @(posedge clk2x or negedge rst_n) begin
        if (!rst_n) begin
            pending   <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= ack;
            if (ack) begin
                pending <= 1'b0;
            end else if (accept) begin
                pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk2x) begin
        if (accept) begin
            is_write   <= req_write;
            address    <= req_addr;
            wrdata     <= req_wdata;
            dataenable <= req_be;
        end
        // Writes leave the last read word on rsp_rdata
        if (ack && !is_write) begin
            rsp_rdata <= rddata;
        end
    end

    // The arbiter acknowledges only an access it took from this adapter
    ack_pending_a: assert property (@(posedge clk2x) disable iff (!rst_n)
        ack |-> pending);

endmodule : port_adapter

`default_nettype wire

// File: rtl/two_port.sv
`timescale 1ns/100ps
`default_nettype none

module two_port (
    input  wire logic             clk2x,
    input  wire logic             rst_n,
    input  wire mem_pkg::addr_t   address1,
    input  wire mem_pkg::word_t   wrdata1,
    input  wire mem_pkg::byte_en_t dataenable1,
    input  wire logic             rd1,
    input  wire logic             wr1,
    output mem_pkg::word_t        rddata1,
    output logic                  ack1,
    input  wire mem_pkg::addr_t   address2,
    input  wire mem_pkg::word_t   wrdata2,
    input  wire mem_pkg::byte_en_t dataenable2,
    input  wire logic             rd2,
    input  wire logic             wr2,
    output mem_pkg::word_t        rddata2,
    output logic                  ack2,
    output mem_pkg::addr_t        ram_address,
    output mem_pkg::word_t        ram_data_o,
    output logic                  ram_wr_n,
    output logic                  ram_rd_n,
    output mem_pkg::byte_en_t     dataenable,
    input  wire mem_pkg::word_t   ram_data_i
);

    import slot_pkg::*;

    slot_t slot;
    logic  pins_active;

    // The pins still show the access issued at the previous edge
    assign pins_active = !ram_wr_n || !ram_rd_n;

    always_ff @(posedge clk2x or negedge rst_n) begin
        if (!rst_n) begin
            slot     <= SLOT_ISSUE1;
            ram_wr_n <= 1'b1;
            ram_rd_n <= 1'b1;
            ack1     <= 1'b0;
            ack2     <= 1'b0;
        end else begin
            slot <= slot_t'({slot[NUM_SLOTS-2:0], slot[NUM_SLOTS-1]});
            ack1 <= 1'b0;
            ack2 <= 1'b0;
            case (slot)
                SLOT_ISSUE1: begin
                    ram_wr_n <= ~wr1;
                    ram_rd_n <= ~rd1;
                end
                SLOT_ISSUE2: begin
                    ram_wr_n <= ~wr2;
                    ram_rd_n <= ~rd2;
                    ack1     <= pins_active;
                end
                SLOT_CAPTURE2: begin
                    ram_wr_n <= 1'b1;
                    ram_rd_n <= 1'b1;
                    ack2     <= pins_active;
                end
                default: begin
                    ram_wr_n <= 1'b1;
                    ram_rd_n <= 1'b1;
                end
            endcase
        end
    end

    // Address, write data and read captures carry no reset
    always_ff @(posedge clk2x) begin
        case (slot)
            SLOT_ISSUE1: begin
                if (rd1 || wr1) begin
                    ram_address <= address1;
                    ram_data_o  <= wrdata1;
                    dataenable  <= dataenable1;
                end
            end
            SLOT_ISSUE2: begin
                rddata1 <= ram_data_i;
                if (rd2 || wr2) begin
                    ram_address <= address2;
                    ram_data_o  <= wrdata2;
                    dataenable  <= dataenable2;
                end
            end
            SLOT_CAPTURE2: begin
                rddata2 <= ram_data_i;
            end
            default: begin
            end
        endcase
    end

    slot_onehot_a: assert property (@(posedge clk2x) disable iff (!rst_n)
        $onehot(slot));

    // The adapters never raise rd and wr together
    pins_exclusive_a: assert property (@(posedge clk2x) disable iff (!rst_n)
        !(!ram_wr_n && !ram_rd_n));

endmodule : two_port

`default_nettype wire

// File: rtl/mem_subsys_top.sv
`timescale 1ns/100ps
`default_nettype none

module mem_subsys_top #(
    parameter int mem_depth_log2 = mem_pkg::MEM_DEPTH_LOG2
) (
    input  wire logic              clk2x,
    input  wire logic              rst_n,
    input  wire logic              p1_req_valid,
    input  wire logic              p1_req_write,
    input  wire mem_pkg::addr_t    p1_req_addr,
    input  wire mem_pkg::word_t    p1_req_wdata,
    input  wire mem_pkg::byte_en_t p1_req_be,
    output logic                   p1_req_ready,
    output logic                   p1_rsp_valid,
    output mem_pkg::word_t         p1_rsp_rdata,
    input  wire logic              p2_req_valid,
    input  wire logic              p2_req_write,
    input  wire mem_pkg::addr_t    p2_req_addr,
    input  wire mem_pkg::word_t    p2_req_wdata,
    input  wire mem_pkg::byte_en_t p2_req_be,
    output logic                   p2_req_ready,
    output logic                   p2_rsp_valid,
    output mem_pkg::word_t         p2_rsp_rdata
);

    import mem_pkg::*;

    logic     p1_rd;
    logic     p1_wr;
    addr_t    p1_address;
    word_t    p1_wrdata;
    byte_en_t p1_dataenable;
    logic     p1_ack;
    word_t    p1_rddata;

    logic     p2_rd;
    logic     p2_wr;
    addr_t    p2_address;
    word_t    p2_wrdata;
    byte_en_t p2_dataenable;
    logic     p2_ack;
    word_t    p2_rddata;

    addr_t    ram_address;
    word_t    ram_data_o;
    word_t    ram_data_i;
    logic     ram_wr_n;
    logic     ram_rd_n;
    byte_en_t ram_dataenable;

    // Instruction fetch takes arbiter port 1
    port_adapter fetch_port (
        .clk2x      (clk2x),
        .rst_n      (rst_n),
        .req_valid  (p1_req_valid),
        .req_write  (p1_req_write),
        .req_addr   (p1_req_addr),
        .req_wdata  (p1_req_wdata),
        .req_be     (p1_req_be),
        .req_ready  (p1_req_ready),
        .rsp_valid  (p1_rsp_valid),
        .rsp_rdata  (p1_rsp_rdata),
        .rd         (p1_rd),
        .wr         (p1_wr),
        .address    (p1_address),
        .wrdata     (p1_wrdata),
        .dataenable (p1_dataenable),
        .ack        (p1_ack),
        .rddata     (p1_rddata)
    );

    port_adapter lsu_port (
        .clk2x      (clk2x),
        .rst_n      (rst_n),
        .req_valid  (p2_req_valid),
        .req_write  (p2_req_write),
        .req_addr   (p2_req_addr),
        .req_wdata  (p2_req_wdata),
        .req_be     (p2_req_be),
        .req_ready  (p2_req_ready),
        .rsp_valid  (p2_rsp_valid),
        .rsp_rdata  (p2_rsp_rdata),
        .rd         (p2_rd),
        .wr         (p2_wr),
        .address    (p2_address),
        .wrdata     (p2_wrdata),
        .dataenable (p2_dataenable),
        .ack        (p2_ack),
        .rddata     (p2_rddata)
    );

    two_port two_port_inst (
        .clk2x       (clk2x),
        .rst_n       (rst_n),
        .address1    (p1_address),
        .wrdata1     (p1_wrdata),
        .dataenable1 (p1_dataenable),
        .rd1         (p1_rd),
        .wr1         (p1_wr),
        .rddata1     (p1_rddata),
        .ack1        (p1_ack),
        .address2    (p2_address),
        .wrdata2     (p2_wrdata),
        .dataenable2 (p2_dataenable),
        .rd2         (p2_rd),
        .wr2         (p2_wr),
        .rddata2     (p2_rddata),
        .ack2        (p2_ack),
        .ram_address (ram_address),
        .ram_data_o  (ram_data_o),
        .ram_wr_n    (ram_wr_n),
        .ram_rd_n    (ram_rd_n),
        .dataenable  (ram_dataenable),
        .ram_data_i  (ram_data_i)
    );

    sram_model #(
        .depth_log2 (mem_depth_log2)
    ) sram_inst (
        .clk2x       (clk2x),
        .ram_address (ram_address),
        .ram_data_o  (ram_data_o),
        .ram_wr_n    (ram_wr_n),
        .ram_rd_n    (ram_rd_n),
        .dataenable  (ram_dataenable),
        .ram_data_i  (ram_data_i)
    );

endmodule : mem_subsys_top

`default_nettype wire

// File: verification/mem_subsys_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mem_subsys_tb;

    import mem_pkg::*;
    import slot_pkg::*;

    localparam int MAX_ROWS     = 32;
    localparam int MAX_LATENCY  = 6;
    localparam int RESET_MARGIN = 8 * NUM_SLOTS;

    logic     clk2x;
    logic     rst_n;
    logic     p1_req_valid;
    logic     p1_req_write;
    addr_t    p1_req_addr;
    word_t    p1_req_wdata;
    byte_en_t p1_req_be;
    logic     p1_req_ready;
    logic     p1_rsp_valid;
    word_t    p1_rsp_rdata;
    logic     p2_req_valid;
    logic     p2_req_write;
    addr_t    p2_req_addr;
    word_t    p2_req_wdata;
    byte_en_t p2_req_be;
    logic     p2_req_ready;
    logic     p2_rsp_valid;
    word_t    p2_rsp_rdata;

    // Stimulus table with one operation per row
    int       row_port  [MAX_ROWS];
    logic     row_write [MAX_ROWS];
    addr_t    row_addr  [MAX_ROWS];
    word_t    row_wdata [MAX_ROWS];
    byte_en_t row_be    [MAX_ROWS];
    logic     row_pair  [MAX_ROWS];
    int       num_rows = 0;

    word_t       ref_mem [0:(1 << MEM_DEPTH_LOG2) - 1];
    logic [31:0] lfsr_state = 32'h64cc;
    int          cycle = 0;
    int          timeout_limit = 0;
    int          error_count = 0;
    int          check_count = 0;
    int          test_count = 0;

    mem_subsys_top #(
        .mem_depth_log2 (MEM_DEPTH_LOG2)
    ) mem_subsys_top_inst (
        .clk2x        (clk2x),
        .rst_n        (rst_n),
        .p1_req_valid (p1_req_valid),
        .p1_req_write (p1_req_write),
        .p1_req_addr  (p1_req_addr),
        .p1_req_wdata (p1_req_wdata),
        .p1_req_be    (p1_req_be),
        .p1_req_ready (p1_req_ready),
        .p1_rsp_valid (p1_rsp_valid),
        .p1_rsp_rdata (p1_rsp_rdata),
        .p2_req_valid (p2_req_valid),
        .p2_req_write (p2_req_write),
        .p2_req_addr  (p2_req_addr),
        .p2_req_wdata (p2_req_wdata),
        .p2_req_be    (p2_req_be),
        .p2_req_ready (p2_req_ready),
        .p2_rsp_valid (p2_rsp_valid),
        .p2_rsp_rdata (p2_rsp_rdata)
    );

    initial begin
        clk2x = 1'b0;
        forever #2 clk2x = ~clk2x;
    end

    always @(posedge clk2x) begin
        cycle <= cycle + 1;
        if (timeout_limit > 0 && cycle >= timeout_limit) begin
            $display("Timeout after %0d cycles, a response never arrived", cycle);
            $display("Done: errors found");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic random_word(output word_t w);
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w[i] = lfsr_state[0];
        end
    endtask

    task automatic add_row(input int port, input logic write, input addr_t addr,
                           input byte_en_t be, input logic pair);
        word_t data;
        data = '0;
        if (write) begin
            random_word(data);
        end
        row_port[num_rows]  = port;
        row_write[num_rows] = write;
        row_addr[num_rows]  = addr;
        row_wdata[num_rows] = data;
        row_be[num_rows]    = be;
        row_pair[num_rows]  = pair;
        num_rows++;
    endtask

    task automatic build_table();
        // Full-word write and read back on each port
        add_row(1, 1'b1, 32'h010, 4'hf, 1'b0);
        add_row(1, 1'b0, 32'h010, 4'h0, 1'b0);
        add_row(2, 1'b1, 32'h020, 4'hf, 1'b0);
        add_row(2, 1'b0, 32'h020, 4'h0, 1'b0);
        // Byte enables merge into the stored word
        add_row(1, 1'b1, 32'h030, 4'hf, 1'b0);
        add_row(1, 1'b1, 32'h030, 4'b0101, 1'b0);
        add_row(1, 1'b0, 32'h030, 4'h0, 1'b0);
        add_row(2, 1'b1, 32'h030, 4'b1000, 1'b0);
        add_row(2, 1'b0, 32'h030, 4'h0, 1'b0);
        // Port 2 sees what port 1 wrote
        add_row(1, 1'b1, 32'h040, 4'hf, 1'b0);
        add_row(2, 1'b0, 32'h040, 4'h0, 1'b0);
        // Both ports at once on different addresses
        add_row(1, 1'b1, 32'h050, 4'hf, 1'b1);
        add_row(2, 1'b1, 32'h060, 4'hf, 1'b0);
        add_row(1, 1'b0, 32'h060, 4'h0, 1'b1);
        add_row(2, 1'b0, 32'h050, 4'h0, 1'b0);
        add_row(1, 1'b0, 32'h030, 4'h0, 1'b1);
        add_row(2, 1'b0, 32'h040, 4'h0, 1'b0);
        // Back-to-back on one port
        add_row(2, 1'b0, 32'h010, 4'h0, 1'b0);
        add_row(2, 1'b0, 32'h020, 4'h0, 1'b0);
        add_row(2, 1'b1, 32'h070, 4'b0011, 1'b0);
        add_row(2, 1'b0, 32'h070, 4'h0, 1'b0);
        add_row(1, 1'b0, 32'h100, 4'h0, 1'b0);
        // Low address bits select nothing
        add_row(1, 1'b0, 32'h012, 4'h0, 1'b0);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %08h expected %08h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    function automatic logic port_ready(input int p);
        return (p == 0) ? p1_req_ready : p2_req_ready;
    endfunction

    function automatic logic port_rsp_valid(input int p);
        return (p == 0) ? p1_rsp_valid : p2_rsp_valid;
    endfunction

    function automatic word_t port_rdata(input int p);
        return (p == 0) ? p1_rsp_rdata : p2_rsp_rdata;
    endfunction

    task automatic drive_request(input int p, input int r, input logic valid);
        if (p == 0) begin
            p1_req_valid <= valid;
            p1_req_write <= row_write[r];
            p1_req_addr  <= row_addr[r];
            p1_req_wdata <= row_wdata[r];
            p1_req_be    <= row_be[r];
        end else begin
            p2_req_valid <= valid;
            p2_req_write <= row_write[r];
            p2_req_addr  <= row_addr[r];
            p2_req_wdata <= row_wdata[r];
            p2_req_be    <= row_be[r];
        end
    endtask

    // Writes update the reference in completion order and reads compare against it
    task automatic complete_row(input int r);
        logic [MEM_DEPTH_LOG2-1:0] idx;
        int                        p;
        idx = row_addr[r][MEM_DEPTH_LOG2+1:2];
        p = row_port[r] - 1;
        if (row_write[r]) begin
            for (int b = 0; b < $bits(byte_en_t); b++) begin
                if (row_be[r][b]) begin
                    ref_mem[idx][8*b +: 8] = row_wdata[r][8*b +: 8];
                end
            end
        end else begin
            check_word($sformatf("p%0d_rsp_rdata", p + 1), port_rdata(p), ref_mem[idx]);
        end
    endtask

    task automatic run_group(input int first, input int count);
        int   row_of      [2];
        logic active      [2];
        logic accepted    [2];
        logic done        [2];
        int   accept_edge [2];
        int   remaining;
        int   latency;
        int   errors_before;
        errors_before = error_count;
        for (int p = 0; p < 2; p++) begin
            row_of[p] = 0;
            active[p] = 1'b0;
            accepted[p] = 1'b0;
            done[p] = 1'b0;
            accept_edge[p] = 0;
        end
        for (int k = 0; k < count; k++) begin
            row_of[row_port[first + k] - 1] = first + k;
            active[row_port[first + k] - 1] = 1'b1;
        end
        remaining = count;
        @(posedge clk2x);
        for (int p = 0; p < 2; p++) begin
            if (active[p]) begin
                drive_request(p, row_of[p], 1'b1);
            end
        end
        while (remaining > 0) begin
            @(negedge clk2x);
            // Port 1 is checked first because it completes first in a shared round
            for (int p = 0; p < 2; p++) begin
                if (port_rsp_valid(p)) begin
                    if (!accepted[p] || done[p]) begin
                        $display("Port %0d gave a response with no request outstanding", p + 1);
                        error_count++;
                    end else begin
                        latency = cycle - accept_edge[p];
                        if (latency < 2 || latency > MAX_LATENCY) begin
                            $display("Port %0d took %0d cycles to respond", p + 1, latency);
                            error_count++;
                        end
                        check_bit($sformatf("p%0d_req_ready", p + 1), port_ready(p), 1'b1);
                        complete_row(row_of[p]);
                        done[p] = 1'b1;
                        remaining--;
                    end
                end
            end
            for (int p = 0; p < 2; p++) begin
                if (active[p] && !accepted[p] && port_ready(p)) begin
                    accepted[p] = 1'b1;
                    accept_edge[p] = cycle + 1;
                end
            end
            if (remaining > 0) begin
                @(posedge clk2x);
                for (int p = 0; p < 2; p++) begin
                    if (accepted[p]) begin
                        drive_request(p, row_of[p], 1'b0);
                    end
                end
            end
        end
        test_count++;
        $display("test %0d rows %0d to %0d %s", test_count, first, first + count - 1,
                 (error_count == errors_before) ? "ok" : "failed");
    endtask

    initial begin
        int r;
        rst_n        = 1'b0;
        p1_req_valid = 1'b0;
        p1_req_write = 1'b0;
        p1_req_addr  = '0;
        p1_req_wdata = '0;
        p1_req_be    = '0;
        p2_req_valid = 1'b0;
        p2_req_write = 1'b0;
        p2_req_addr  = '0;
        p2_req_wdata = '0;
        p2_req_be    = '0;
        for (int i = 0; i < (1 << MEM_DEPTH_LOG2); i++) begin
            ref_mem[i] = '0;
        end
        build_table();
        timeout_limit = num_rows * 2 * NUM_SLOTS + RESET_MARGIN;

        repeat (4) @(posedge clk2x);
        rst_n <= 1'b1;
        @(negedge clk2x);
        check_bit("p1_req_ready", p1_req_ready, 1'b1);
        check_bit("p2_req_ready", p2_req_ready, 1'b1);
        check_bit("p1_rsp_valid", p1_rsp_valid, 1'b0);
        check_bit("p2_rsp_valid", p2_rsp_valid, 1'b0);
        test_count++;
        $display("test %0d reset state %s", test_count, (error_count == 0) ? "ok" : "failed");

        r = 0;
        while (r < num_rows) begin
            if (row_pair[r] && r + 1 < num_rows) begin
                run_group(r, 2);
                r = r + 2;
            end else begin
                run_group(r, 1);
                r = r + 1;
            end
        end

        // No late or repeated strobes once everything has completed
        repeat (2 * NUM_SLOTS) begin
            @(negedge clk2x);
            check_bit("p1_rsp_valid", p1_rsp_valid, 1'b0);
            check_bit("p2_rsp_valid", p2_rsp_valid, 1'b0);
        end

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule : mem_subsys_tb

`default_nettype wire

// File: filelist.f
rtl/mem_pkg.sv
rtl/slot_pkg.sv
rtl/sram_model.sv
rtl/port_adapter.sv
rtl/two_port.sv
rtl/mem_subsys_top.sv
verification/mem_subsys_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := mem_subsys_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Done: no errors

SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qxF "$(PASS_MSG)" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
